// File: bench/ctrl_fsm_checker.sv
/*
  Assertions on the retire FSM, attached to every ctrl_fsm instance by bind.
  Covers the redirect pulse and the flush request and acknowledge handshake.
*/

`default_nettype none

module ctrl_fsm_checker (
  input wire logic             clk,
  input wire logic             rst_n_i,
  input wire ctrl_pkg::state_e state_i,
  input wire logic             flush_req_i,
  input wire logic             flush_ack_i,
  input wire logic             redirect_i,
  input wire logic             wb_valid_i
);

  // Number of failed assertions so far
  int unsigned fail_count = 0;

  // A redirect is a single cycle pulse
  redirect_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    redirect_i |=> !redirect_i)
    else begin
      fail_count = fail_count + 1;
      $error("redirect_o high in two consecutive cycles");
    end

  // The request only exists while the FSM waits for the acknowledge
  req_in_state: assert property (@(posedge clk) disable iff (!rst_n_i)
    flush_req_i |-> (state_i == ctrl_pkg::ST_FLUSH_REQ))
    else begin
      fail_count = fail_count + 1;
      $error("flush_req_o high outside ST_FLUSH_REQ");
    end

  req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    (flush_req_i && !flush_ack_i) |=> flush_req_i)
    else begin
      fail_count = fail_count + 1;
      $error("flush_req_o dropped before flush_ack_i");
    end

  req_drops: assert property (@(posedge clk) disable iff (!rst_n_i)
    (flush_req_i && flush_ack_i) |=> !flush_req_i)
    else begin
      fail_count = fail_count + 1;
      $error("flush_req_o still high after the acknowledge");
    end

  // The fence retires right after its flush completes
  fence_retires: assert property (@(posedge clk) disable iff (!rst_n_i)
    $fell(flush_req_i) |=> wb_valid_i)
    else begin
      fail_count = fail_count + 1;
      $error("no writeback after flush_req_o fell");
    end

endmodule

bind ctrl_fsm ctrl_fsm_checker u_checker (
  .clk(clk),
  .rst_n_i(rst_n_i),
  .state_i(state_q),
  .flush_req_i(flush_req_o),
  .flush_ack_i(flush_ack_i),
  .redirect_i(redirect_o),
  .wb_valid_i(wb_valid_o)
);

`default_nettype wire

// File: bench/ctrl_monitor.sv
/*
  Monitor of the retire controller ports.
  Queues every accepted instruction, runs the opcode rules on a model
  accumulator and compares each writeback with the model.
*/

`default_nettype none

module ctrl_monitor #(
  parameter int unsigned DATA_W = 16
) (
  input  wire logic              clk,
  input  wire logic              rst_n_i,
  input  wire logic              instr_valid_i,
  input  wire ctrl_pkg::op_e     instr_op_i,
  input  wire logic [DATA_W-1:0] instr_imm_i,
  input  wire logic              instr_ready_i,
  input  wire logic              flush_req_i,
  input  wire logic              wb_valid_i,
  input  wire ctrl_pkg::op_e     wb_op_i,
  input  wire logic [DATA_W-1:0] wb_result_i,
  input  wire logic              redirect_i,
  output int unsigned            accepted_o,
  output int unsigned            retired_o,
  output int unsigned            killed_o,
  output int unsigned            errors_o,
  output int unsigned            stalls_o,
  output int unsigned            redirects_o,
  output int unsigned            pending_o
);

  // Issue register, then the buffer head, then the registered writeback
  localparam int unsigned MIN_LATENCY = 3;

  // Instructions accepted and not yet retired or killed, oldest first
  ctrl_pkg::op_e     op_q[$];
  logic [DATA_W-1:0] imm_q[$];
  int unsigned       cyc_q[$];

  logic [DATA_W-1:0] model_acc = '0;
  logic [DATA_W-1:0] exp_acc;
  logic [DATA_W-1:0] exp_imm;
  ctrl_pkg::op_e     exp_op;
  logic              exp_redirect;
  int unsigned       exp_cyc;
  logic              kill_now;
  logic              rst_q1 = 1'b1;
  logic              rst_q2 = 1'b1;
  int unsigned       cycle = 0;
  int unsigned       accepted = 0;
  int unsigned       retired = 0;
  int unsigned       killed = 0;
  int unsigned       errors = 0;
  int unsigned       stalls = 0;
  int unsigned       redirects = 0;
  int unsigned       pending = 0;

  // Only an add changes the accumulator, and it wraps at DATA_W bits
  function automatic logic [DATA_W-1:0] apply_op(input ctrl_pkg::op_e op,
                                                 input logic [DATA_W-1:0] imm,
                                                 input logic [DATA_W-1:0] acc);
    if (op == ctrl_pkg::OP_ADD) begin
      return acc + imm;
    end
    return acc;
  endfunction

  task automatic check_hex(input string name, input logic [DATA_W-1:0] exp,
                           input logic [DATA_W-1:0] act);
    if (exp !== act) begin
      errors++;
      $display("Error: %s expected %h, got %h at cycle %0d", name, exp, act, cycle);
    end
  endtask

  always @(posedge clk) begin
    cycle++;
    // Reset was applied at the previous edge, so every control output is low
    if (!rst_q1) begin
      check_hex("instr_ready_o", '0, DATA_W'(instr_ready_i));
      check_hex("wb_valid_o", '0, DATA_W'(wb_valid_i));
      check_hex("redirect_o", '0, DATA_W'(redirect_i));
      check_hex("flush_req_o", '0, DATA_W'(flush_req_i));
    end
    // First cycle after reset release opens the input
    if (!rst_q2 && rst_q1) begin
      check_hex("instr_ready_o", DATA_W'(1), DATA_W'(instr_ready_i));
    end
    rst_q2 = rst_q1;
    rst_q1 = rst_n_i;
    kill_now = 1'b0;
    if (!rst_n_i) begin
      model_acc = '0;
      op_q.delete();
      imm_q.delete();
      cyc_q.delete();
    end else begin
      if (redirect_i) begin
        redirects++;
      end
      // Every writeback is counted, whether the model expected it or not
      if (wb_valid_i) begin
        retired++;
      end
      if (wb_valid_i && (op_q.size() == 0)) begin
        errors++;
        $display("Writeback at cycle %0d with no accepted instruction outstanding", cycle);
      end else if (wb_valid_i) begin
        exp_op = op_q.pop_front();
        exp_imm = imm_q.pop_front();
        exp_cyc = cyc_q.pop_front();
        exp_acc = apply_op(exp_op, exp_imm, model_acc);
        // Bit 0 of a branch immediate makes it taken
        exp_redirect = (exp_op == ctrl_pkg::OP_BRANCH) && exp_imm[0];
        check_hex("wb_op_o", DATA_W'(exp_op), DATA_W'(wb_op_i));
        check_hex("wb_result_o", exp_acc, wb_result_i);
        check_hex("redirect_o", DATA_W'(exp_redirect), DATA_W'(redirect_i));
        if (cycle - exp_cyc < MIN_LATENCY) begin
          errors++;
          $display("Writeback at cycle %0d of an instruction accepted at cycle %0d is too early",
                   cycle, exp_cyc);
        end
        model_acc = exp_acc;
        // Everything still queued is younger and was accepted before this cycle
        if (exp_redirect) begin
          killed += op_q.size();
          op_q.delete();
          imm_q.delete();
          cyc_q.delete();
          kill_now = 1'b1;
        end
      end else begin
        check_hex("redirect_o", '0, DATA_W'(redirect_i));
      end
      if (instr_valid_i && instr_ready_i) begin
        accepted++;
        // Accepted in the redirect cycle itself, so it must never retire
        if (kill_now) begin
          killed++;
        end else begin
          op_q.push_back(instr_op_i);
          imm_q.push_back(instr_imm_i);
          cyc_q.push_back(cycle);
        end
      end
      if (instr_valid_i && !instr_ready_i) begin
        stalls++;
      end
    end
    pending = op_q.size();
  end

  assign accepted_o  = accepted;
  assign retired_o   = retired;
  assign killed_o    = killed;
  assign errors_o    = errors;
  assign stalls_o    = stalls;
  assign redirects_o = redirects;
  assign pending_o   = pending;

endmodule

`default_nettype wire

// File: bench/tb_top.sv
/*
  Testbench top for the retire controller.
  Drives instruction streams into the DUT, answers flush requests after a
  random delay, and prints one line per test and a closing summary.
*/

`default_nettype none

module tb_top;

  localparam int unsigned DATA_W    = ctrl_pkg::DATA_W_DEFAULT;
  localparam int unsigned BUF_DEPTH = ctrl_pkg::BUF_DEPTH_DEFAULT;
  // Instructions sent by the five tests together
  localparam int unsigned N_INSTR = 12 + 8 + 7 + 6 + 40;
  // A fence pays the fill, the handshake and up to five cycles of ack delay
  localparam int unsigned WORST_CYCLES = 14;
  localparam int unsigned MAX_CYCLES = N_INSTR * WORST_CYCLES + 100;

  logic              clk = 1'b0;
  logic              rst_n_i;
  logic              instr_valid_i;
  ctrl_pkg::op_e     instr_op_i;
  logic [DATA_W-1:0] instr_imm_i;
  logic              instr_ready_o;
  logic              flush_req_o;
  logic              flush_ack_i;
  logic              wb_valid_o;
  ctrl_pkg::op_e     wb_op_o;
  logic [DATA_W-1:0] wb_result_o;
  logic              redirect_o;

  int unsigned n_accepted;
  int unsigned n_retired;
  int unsigned n_killed;
  int unsigned n_mon_errors;
  int unsigned n_stalls;
  int unsigned n_redirects;
  int unsigned n_pending;
  int unsigned tb_errors = 0;
  int unsigned cycles = 0;
  int unsigned ack_delay;
  integer      seed = 32'h8178;

  //////////////////////////////
  // Clock, DUT and monitor
  //////////////////////////////

  always #5 clk = ~clk;

  ctrl_top #(.DATA_W(DATA_W), .BUF_DEPTH(BUF_DEPTH)) uut (
    .clk(clk), .rst_n_i(rst_n_i),
    .instr_valid_i(instr_valid_i), .instr_op_i(instr_op_i),
    .instr_imm_i(instr_imm_i), .instr_ready_o(instr_ready_o),
    .flush_req_o(flush_req_o), .flush_ack_i(flush_ack_i),
    .wb_valid_o(wb_valid_o), .wb_op_o(wb_op_o), .wb_result_o(wb_result_o),
    .redirect_o(redirect_o)
  );

  ctrl_monitor #(.DATA_W(DATA_W)) u_monitor (
    .clk(clk), .rst_n_i(rst_n_i),
    .instr_valid_i(instr_valid_i), .instr_op_i(instr_op_i),
    .instr_imm_i(instr_imm_i), .instr_ready_i(instr_ready_o),
    .flush_req_i(flush_req_o), .wb_valid_i(wb_valid_o), .wb_op_i(wb_op_o),
    .wb_result_i(wb_result_o), .redirect_i(redirect_o),
    .accepted_o(n_accepted), .retired_o(n_retired), .killed_o(n_killed),
    .errors_o(n_mon_errors), .stalls_o(n_stalls), .redirects_o(n_redirects),
    .pending_o(n_pending)
  );

  // Ends a run that stopped making progress
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, instructions are still outstanding", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // Flush responder, acknowledges each request after 0 to 5 cycles
  // The delay is drawn on the edge so it never races the stimulus draws
  initial begin
    flush_ack_i = 1'b0;
    forever begin
      @(posedge clk);
      ack_delay = $unsigned($random(seed)) % 6;
      #1;
      if (flush_req_o) begin
        repeat (ack_delay) @(posedge clk);
        #1;
        flush_ack_i = 1'b1;
        @(posedge clk);
        #1;
        flush_ack_i = 1'b0;
      end
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Moves to 1 time unit after the next rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // Holds the instruction until the edge that transfers it
  task automatic send(input ctrl_pkg::op_e op, input logic [DATA_W-1:0] imm);
    instr_valid_i = 1'b1;
    instr_op_i    = op;
    instr_imm_i   = imm;
    while (!instr_ready_o) step();
    step();
    instr_valid_i = 1'b0;
  endtask

  // Opcodes are drawn from the first n_ops encodings
  task automatic send_random(input int unsigned count, input int unsigned n_ops);
    int unsigned r;
    for (int i = 0; i < count; i++) begin
      r = $unsigned($random(seed));
      send(ctrl_pkg::op_e'(3'(r % n_ops)), DATA_W'($random(seed)));
    end
  endtask

  // Waits until every accepted instruction has retired or been killed
  task automatic drain();
    while (n_pending != 0) step();
    repeat (2) step();
  endtask

  function automatic int unsigned total_errors();
    return n_mon_errors + tb_errors + uut.u_fsm.u_checker.fail_count;
  endfunction

  task automatic report(input int unsigned num, input string name, input int unsigned err0);
    $display("test %0d %s: %0d retired, %0d killed so far, %0d errors", num, name,
             n_retired, n_killed, total_errors() - err0);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int unsigned err0;
    int unsigned kills0;
    int unsigned redir0;
    int unsigned stall0;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_op_i    = ctrl_pkg::OP_NOP;
    instr_imm_i   = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    // Adds that wrap, then a random add and nop stream
    err0 = total_errors();
    send(ctrl_pkg::OP_ADD, DATA_W'('hFFF0));
    send(ctrl_pkg::OP_ADD, DATA_W'('h0025));
    send(ctrl_pkg::OP_NOP, DATA_W'('h1234));
    send(ctrl_pkg::OP_ADD, DATA_W'('h8000));
    send_random(8, 2);
    drain();
    report(1, "add and nop stream", err0);

    // Taken branch first, then a not-taken one
    err0   = total_errors();
    kills0 = n_killed;
    redir0 = n_redirects;
    send(ctrl_pkg::OP_BRANCH, DATA_W'('h0003));
    repeat (3) send(ctrl_pkg::OP_ADD, DATA_W'('h0011));
    drain();
    if ((n_killed == kills0) || (n_redirects != redir0 + 1)) begin
      tb_errors++;
      $display("Taken branch gave %0d kills and %0d redirects, wanted kills and one redirect",
               n_killed - kills0, n_redirects - redir0);
    end
    kills0 = n_killed;
    redir0 = n_redirects;
    send(ctrl_pkg::OP_BRANCH, DATA_W'('h0002));
    repeat (3) send(ctrl_pkg::OP_ADD, DATA_W'('h0022));
    drain();
    if ((n_killed != kills0) || (n_redirects != redir0)) begin
      tb_errors++;
      $display("Not-taken branch killed instructions or redirected");
    end
    report(2, "branches", err0);

    // Fences with random acknowledge delays
    err0 = total_errors();
    send(ctrl_pkg::OP_ADD, DATA_W'('h0100));
    repeat (3) begin
      send(ctrl_pkg::OP_FENCE, DATA_W'($random(seed)));
      send(ctrl_pkg::OP_ADD, DATA_W'('h0001));
    end
    drain();
    report(3, "fences", err0);

    // A fence at the head lets the adds behind it fill the buffer
    err0   = total_errors();
    stall0 = n_stalls;
    send(ctrl_pkg::OP_FENCE, DATA_W'('h0000));
    repeat (5) send(ctrl_pkg::OP_ADD, DATA_W'($random(seed)));
    drain();
    if (n_stalls == stall0) begin
      tb_errors++;
      $display("instr_ready_o never fell while the buffer was full");
    end
    report(4, "back-pressure", err0);

    err0 = total_errors();
    send_random(40, 4);
    drain();
    if (n_retired != n_accepted - n_killed) begin
      tb_errors++;
      $display("Retired count does not match accepted minus killed");
    end
    report(5, "random mix", err0);

    $display("Summary: 5 tests, %0d accepted, %0d retired, %0d killed, %0d errors",
             n_accepted, n_retired, n_killed, total_errors());
    if (total_errors() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# A raised error limit lets the run reach its own summary after an assertion
out=$(./obj_dir/Vtb_top +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

// File: src/ctrl_fsm.sv
/*
  Retire state machine of the controller.
  Pops the buffer head, updates the accumulator and reports each retirement
  on the writeback port. Taken branches redirect and kill, fences run the
  flush request and acknowledge handshake before they retire.
*/

`default_nettype none

module ctrl_fsm #(
  parameter int unsigned DATA_W = 16
) (
  input  wire logic              clk,
  input  wire logic              rst_n_i,
  input  wire logic              head_valid_i,
  input  wire ctrl_pkg::op_e     head_op_i,
  input  wire logic [DATA_W-1:0] head_imm_i,
  input  wire logic              head_taken_i,
  output logic                   pop_o,
  output logic                   kill_o,
  output logic                   flush_req_o,
  input  wire logic              flush_ack_i,
  output logic                   wb_valid_o,
  output ctrl_pkg::op_e          wb_op_o,
  output logic [DATA_W-1:0]      wb_result_o,
  output logic                   redirect_o
);

  ctrl_pkg::state_e  state_q;
  ctrl_pkg::state_e  state_d;
  logic [DATA_W-1:0] acc_q;
  logic              flush_req_q;
  logic              wb_valid_q;
  logic              redirect_q;
  logic              redirect_d;
  ctrl_pkg::op_e     wb_op_q;

  //////////////////////////////
  // Next state and pop
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    pop_o   = 1'b0;
    case (state_q)
      ctrl_pkg::ST_RUN: begin
        if (head_valid_i) begin
          // A fence stays at the head until the flush has been acknowledged
          if (head_op_i == ctrl_pkg::OP_FENCE) begin
            state_d = ctrl_pkg::ST_FLUSH_REQ;
          end else begin
            pop_o = 1'b1;
          end
        end
      end
      ctrl_pkg::ST_FLUSH_REQ: begin
        if (flush_req_q && flush_ack_i) begin
          state_d = ctrl_pkg::ST_FLUSH_DONE;
        end
      end
      ctrl_pkg::ST_FLUSH_DONE: begin
        // The fence leaves the buffer here
        pop_o   = 1'b1;
        state_d = ctrl_pkg::ST_RUN;
      end
      default: begin
        state_d = ctrl_pkg::ST_RUN;
      end
    endcase
  end

  // Only a branch resolved as taken at issue redirects
  assign redirect_d = pop_o && (state_q == ctrl_pkg::ST_RUN) && head_taken_i;

  // Kill covers the pop cycle and the redirect cycle after it
  // In the second cycle the input stays closed, so no younger instruction
  // gets in before the redirect is visible outside
  assign kill_o = redirect_d || redirect_q;

  //////////////////////////////
  // Control registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q     <= ctrl_pkg::ST_RUN;
      flush_req_q <= 1'b0;
      wb_valid_q  <= 1'b0;
      redirect_q  <= 1'b0;
      acc_q       <= '0;
    end else begin
      state_q    <= state_d;
      wb_valid_q <= pop_o;
      redirect_q <= redirect_d;
      // Request rises on entry to ST_FLUSH_REQ and falls after the ack
      if ((state_q == ctrl_pkg::ST_RUN) && (state_d == ctrl_pkg::ST_FLUSH_REQ)) begin
        flush_req_q <= 1'b1;
      end else if (flush_req_q && flush_ack_i) begin
        flush_req_q <= 1'b0;
      end
      // Wraps at DATA_W bits, other opcodes leave it alone
      if (pop_o && (head_op_i == ctrl_pkg::OP_ADD)) begin
        acc_q <= acc_q + head_imm_i;
      end
    end
  end

  // Opcode of the retiring instruction, only meaningful with wb_valid_o
  always_ff @(posedge clk) begin
    if (pop_o) begin
      wb_op_q <= head_op_i;
    end
  end

  assign flush_req_o = flush_req_q;
  assign wb_valid_o  = wb_valid_q;
  assign wb_op_o     = wb_op_q;
  // The accumulator already holds the value after the retired instruction
  assign wb_result_o = acc_q;
  assign redirect_o  = redirect_q;

endmodule

`default_nettype wire

// File: src/ctrl_pkg.sv
/*
  Shared definitions of the retire controller.
  Holds the opcode and state encodings and the default widths. Every block
  refers to these by scoped names.
*/

`default_nettype none

package ctrl_pkg;

  //////////////////////////////
  // Instruction encoding
  //////////////////////////////

  // Opcodes carried from the input port down to the writeback port
  typedef enum logic [2:0] {
    OP_NOP    = 3'd0,
    OP_ADD    = 3'd1,
    OP_BRANCH = 3'd2,
    OP_FENCE  = 3'd3
  } op_e;

  //////////////////////////////
  // Retire controller states
  //////////////////////////////

  // Normal retirement, waiting for the flush acknowledge, retiring the fence
  typedef enum logic [1:0] {
    ST_RUN        = 2'd0,
    ST_FLUSH_REQ  = 2'd1,
    ST_FLUSH_DONE = 2'd2
  } state_e;

  // Width of the immediate and of the accumulator
  localparam int unsigned DATA_W_DEFAULT = 16;

  // Number of buffer entries, a power of two
  localparam int unsigned BUF_DEPTH_DEFAULT = 2;

endpackage

`default_nettype wire

// File: src/ctrl_top.sv
/*
  Top level of the retire controller.
  Chains issue stage, instruction buffer and retire FSM, and hands the width
  and depth parameters down to them.
*/

`default_nettype none

module ctrl_top #(
  parameter int unsigned DATA_W    = ctrl_pkg::DATA_W_DEFAULT,
  parameter int unsigned BUF_DEPTH = ctrl_pkg::BUF_DEPTH_DEFAULT
) (
  input  wire logic              clk,
  input  wire logic              rst_n_i,
  input  wire logic              instr_valid_i,
  input  wire ctrl_pkg::op_e     instr_op_i,
  input  wire logic [DATA_W-1:0] instr_imm_i,
  output logic                   instr_ready_o,
  output logic                   flush_req_o,
  input  wire logic              flush_ack_i,
  output logic                   wb_valid_o,
  output ctrl_pkg::op_e          wb_op_o,
  output logic [DATA_W-1:0]      wb_result_o,
  output logic                   redirect_o
);

  // Issue to buffer
  logic              iss_valid;
  logic              iss_ready;
  ctrl_pkg::op_e     iss_op;
  logic [DATA_W-1:0] iss_imm;
  logic              iss_taken;

  // Buffer head to the retire FSM
  logic              buf_valid;
  logic              buf_pop;
  ctrl_pkg::op_e     buf_op;
  logic [DATA_W-1:0] buf_imm;
  logic              buf_taken;
  logic              kill;

  issue_stage #(.DATA_W(DATA_W)) u_issue (
    .clk(clk), .rst_n_i(rst_n_i),
    .instr_valid_i(instr_valid_i), .instr_op_i(instr_op_i),
    .instr_imm_i(instr_imm_i), .instr_ready_o(instr_ready_o), .kill_i(kill),
    .iss_valid_o(iss_valid), .iss_op_o(iss_op), .iss_imm_o(iss_imm),
    .iss_taken_o(iss_taken), .iss_ready_i(iss_ready)
  );

  instr_buffer #(.DATA_W(DATA_W), .BUF_DEPTH(BUF_DEPTH)) u_buf (
    .clk(clk), .rst_n_i(rst_n_i), .kill_i(kill),
    .in_valid_i(iss_valid), .in_op_i(iss_op), .in_imm_i(iss_imm),
    .in_taken_i(iss_taken), .in_ready_o(iss_ready),
    .out_valid_o(buf_valid), .out_op_o(buf_op), .out_imm_o(buf_imm),
    .out_taken_o(buf_taken), .pop_i(buf_pop)
  );

  ctrl_fsm #(.DATA_W(DATA_W)) u_fsm (
    .clk(clk), .rst_n_i(rst_n_i),
    .head_valid_i(buf_valid), .head_op_i(buf_op), .head_imm_i(buf_imm),
    .head_taken_i(buf_taken), .pop_o(buf_pop), .kill_o(kill),
    .flush_req_o(flush_req_o), .flush_ack_i(flush_ack_i),
    .wb_valid_o(wb_valid_o), .wb_op_o(wb_op_o), .wb_result_o(wb_result_o),
    .redirect_o(redirect_o)
  );

endmodule

`default_nettype wire

// File: src/instr_buffer.sv
/*
  Instruction buffer between issue and retire.
  A circular FIFO of BUF_DEPTH entries with push and pop in the same cycle.
  A kill empties it at once by resetting the pointers.
*/

`default_nettype none

module instr_buffer #(
  parameter int unsigned DATA_W    = 16,
  parameter int unsigned BUF_DEPTH = 2
) (
  input  wire logic              clk,
  input  wire logic              rst_n_i,
  input  wire logic              kill_i,
  input  wire logic              in_valid_i,
  input  wire ctrl_pkg::op_e     in_op_i,
  input  wire logic [DATA_W-1:0] in_imm_i,
  input  wire logic              in_taken_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  output ctrl_pkg::op_e          out_op_o,
  output logic [DATA_W-1:0]      out_imm_o,
  output logic                   out_taken_o,
  input  wire logic              pop_i
);

  localparam int unsigned PTR_W = $clog2(BUF_DEPTH);
  localparam int unsigned CNT_W = PTR_W + 1;
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(BUF_DEPTH);

  ctrl_pkg::op_e     op_mem    [BUF_DEPTH];
  logic [DATA_W-1:0] imm_mem   [BUF_DEPTH];
  logic              taken_mem [BUF_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign in_ready_o  = (count_q != FULL_CNT);
  assign out_valid_o = (count_q != '0);
  assign push        = in_valid_i && in_ready_o;
  assign pop         = pop_i && out_valid_o;

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n_i || kill_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Storage is written on every push, a killed entry is simply never read
  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr_q]    <= in_op_i;
      imm_mem[wr_ptr_q]   <= in_imm_i;
      taken_mem[wr_ptr_q] <= in_taken_i;
    end
  end

  assign out_op_o    = op_mem[rd_ptr_q];
  assign out_imm_o   = imm_mem[rd_ptr_q];
  assign out_taken_o = taken_mem[rd_ptr_q];

endmodule

`default_nettype wire

// File: src/issue_stage.sv
/*
  Issue stage of the retire controller.
  Takes instructions from the valid/ready input port into one register and
  offers them to the instruction buffer. The branch decision is made here.
*/

`default_nettype none

module issue_stage #(
  parameter int unsigned DATA_W = 16
) (
  input  wire logic              clk,
  input  wire logic              rst_n_i,
  input  wire logic              instr_valid_i,
  input  wire ctrl_pkg::op_e     instr_op_i,
  input  wire logic [DATA_W-1:0] instr_imm_i,
  output logic                   instr_ready_o,
  input  wire logic              kill_i,
  output logic                   iss_valid_o,
  output ctrl_pkg::op_e          iss_op_o,
  output logic [DATA_W-1:0]      iss_imm_o,
  output logic                   iss_taken_o,
  input  wire logic              iss_ready_i
);

  // Goes high one cycle after reset and stays there
  logic alive_q;
  logic valid_q;
  logic accept;

  // The register may refill in the same cycle in which the buffer takes it
  // A kill blocks acceptance so nothing younger than the branch slips in
  assign instr_ready_o = alive_q && !kill_i && (!valid_q || iss_ready_i);
  assign accept        = instr_valid_i && instr_ready_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      alive_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      alive_q <= 1'b1;
      if (kill_i) begin
        valid_q <= 1'b0;
      end else if (accept) begin
        valid_q <= 1'b1;
      end else if (iss_ready_i) begin
        // Drained into the buffer with nothing new behind it
        valid_q <= 1'b0;
      end
    end
  end

  // Payload follows the valid bit and needs no clearing
  // Bit 0 of a branch immediate decides whether it is taken
  always_ff @(posedge clk) begin
    if (accept) begin
      iss_op_o    <= instr_op_i;
      iss_imm_o   <= instr_imm_i;
      iss_taken_o <= (instr_op_i == ctrl_pkg::OP_BRANCH) && instr_imm_i[0];
    end
  end

  assign iss_valid_o = valid_q;

endmodule

`default_nettype wire

// File: tb.f
src/ctrl_pkg.sv
src/issue_stage.sv
src/instr_buffer.sv
src/ctrl_fsm.sv
src/ctrl_top.sv
bench/ctrl_fsm_checker.sv
bench/ctrl_monitor.sv
bench/tb_top.sv
